// ==== verilog/vending_pkg.sv ====
`default_nettype none

package vending_pkg;

    ////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////

    // credit or coin amount in 100 won units
    typedef logic [6:0] money_t;
    // stock of one product
    typedef logic [3:0] count_t;
    // 0 is no product, 1 to 4 are products
    typedef logic [2:0] prod_id_t;
    // cursor position 0..3
    typedef logic [1:0] cursor_t;

    typedef enum logic [1:0] {
        mode_idle,
        mode_coin_hold,
        mode_returning
    } credit_mode_t;

    ////////////////////////////////////////////////
    // button bus bit positions
    ////////////////////////////////////////////////
    localparam int btn_coin_lo   = 0;
    localparam int btn_return    = 3;
    localparam int btn_move_down = 4;
    localparam int btn_restock   = 5;
    localparam int btn_select    = 7;
    localparam int btn_buy       = 9;
    localparam int btn_move_up   = 10;
    localparam int btn_admin     = 11;

    // coin values, bit 2 / bit 1 / bit 0 of the coin field
    localparam money_t coin_small = 7'd1;
    localparam money_t coin_mid   = 7'd5;
    localparam money_t coin_large = 7'd10;

    localparam int num_products = 4;

    // index 0 is product 1
    localparam money_t [num_products-1:0] prod_price      = {7'd18, 7'd15, 7'd12, 7'd10};
    localparam count_t [num_products-1:0] prod_init_count = {4'd4, 4'd0, 4'd1, 4'd9};

    localparam count_t stock_limit   = 4'd9;
    localparam money_t credit_max    = 7'd99;
    localparam int     history_depth = 9;

    // simulation scale timer limits
    localparam int coin_hold_cycles   = 20;
    localparam int return_step_cycles = 10;
    localparam int timer_w            = $clog2(coin_hold_cycles);

endpackage

`default_nettype wire

// ==== verilog/product_selector.sv ====
`timescale 1ns/1ps
`default_nettype none

module product_selector (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  move_up,
    input  logic                  move_down,
    input  logic                  select_toggle,
    input  logic                  admin_toggle,
    input  logic                  buy,
    input  vending_pkg::count_t   prod_count_current,
    output vending_pkg::cursor_t  cursor,
    output vending_pkg::prod_id_t selected_item,
    output logic                  admin_mode
);
    import vending_pkg::*;

    localparam cursor_t cursor_top    = 2'd0;
    localparam cursor_t cursor_bottom = 2'd3;

    // product number under the cursor
    prod_id_t cursor_item;
    logic     cursor_is_selected;

    assign cursor_item        = prod_id_t'(cursor) + prod_id_t'(1);
    assign cursor_is_selected = (selected_item == cursor_item);

    //////////////////////////////////////////////////
    // cursor movement
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor <= cursor_top;
        end else if (move_up) begin
            // up goes toward product 1
            if (cursor != cursor_top) begin
                cursor <= cursor - cursor_t'(1);
            end
        end else if (move_down) begin
            if (cursor != cursor_bottom) begin
                cursor <= cursor + cursor_t'(1);
            end
        end
    end

    //////////////////////////////////////////////////
    // selection
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            selected_item <= '0;
        end else if (select_toggle) begin
            if (cursor_is_selected) begin
                // second press on same product deselects
                selected_item <= '0;
            end else if (prod_count_current != '0) begin
                selected_item <= cursor_item;
            end
        end else if (buy) begin
            selected_item <= '0;
        end
    end

    // admin flag
    always_ff @(posedge clk) begin
        if (!rst) begin
            admin_mode <= 1'b0;
        end else if (admin_toggle) begin
            admin_mode <= ~admin_mode;
        end
    end

    // button bus carries at most one strobe per cycle
    a_strobes_onehot: assert property (
        @(posedge clk) disable iff (!rst)
        $onehot0({move_up, move_down, select_toggle, admin_toggle, buy})
    );

endmodule

`default_nettype wire

// ==== verilog/stock_keeper.sv ====
`timescale 1ns/1ps
`default_nettype none

module stock_keeper (
    input  logic                  clk,
    input  logic                  rst,
    input  vending_pkg::cursor_t  cursor,
    input  vending_pkg::prod_id_t selected_item,
    input  logic                  admin_mode,
    input  logic                  sell,
    input  logic                  restock,
    output vending_pkg::count_t   prod_count_current,
    output vending_pkg::count_t   selected_stock
);
    import vending_pkg::*;

    count_t  stock [num_products];
    cursor_t sel_idx;

    // product n lives at index n-1
    assign sel_idx = cursor_t'(selected_item - prod_id_t'(1));

    //////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < num_products; i++) begin
                stock[i] <= prod_init_count[i];
            end
        end else if (sell) begin
            stock[sel_idx] <= stock[sel_idx] - count_t'(1);
        end else if (restock && admin_mode) begin
            // refill one at a time, capped
            if (stock[cursor] < stock_limit) begin
                stock[cursor] <= stock[cursor] + count_t'(1);
            end
        end
    end

    //////////////////////////////////////////////////
    // readout
    //////////////////////////////////////////////////

    assign prod_count_current = stock[cursor];

    always_comb begin
        if (selected_item == '0) begin
            selected_stock = '0;
        end else begin
            selected_stock = stock[sel_idx];
        end
    end

    // the ledger only sells a product that is in stock
    a_sell_in_stock: assert property (
        @(posedge clk) disable iff (!rst)
        sell |-> (selected_stock != '0)
    );

endmodule

`default_nettype wire

// ==== verilog/credit_ledger.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_ledger (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [2:0]            coin,
    input  logic                  buy,
    input  logic                  return_req,
    input  vending_pkg::prod_id_t selected_item,
    input  vending_pkg::count_t   selected_stock,
    output logic                  sell,
    output vending_pkg::money_t   display_money,
    output logic                  sale_done,
    output logic                  short_money
);
    import vending_pkg::*;

    // running totals, entry 0 is the current credit
    money_t             history [history_depth];
    logic               history_disabled;
    credit_mode_t       mode;
    // shared by coin hold and return steps
    logic [timer_w-1:0] timer;
    money_t             coin_shown;

    money_t  credit;
    money_t  coin_val;
    money_t  coin_sum;
    money_t  price;
    money_t  step_credit;
    cursor_t sel_idx;
    logic    coin_ok;
    logic    buy_ok;
    logic    short_req;
    logic    timer_done;
    logic    return_step;
    logic    return_empty;

    assign credit = history[0];

    always_comb begin
        case (coin)
            3'b100:  coin_val = coin_small;
            3'b010:  coin_val = coin_mid;
            3'b001:  coin_val = coin_large;
            default: coin_val = '0;
        endcase
    end

    // max 99 + 10 still fits 7 bits
    assign coin_sum = credit + coin_val;
    assign coin_ok  = (coin_val != '0) && (coin_sum <= credit_max) && (mode != mode_returning);

    //////////////////////////////////////////////////
    // purchase decision
    //////////////////////////////////////////////////

    assign sel_idx   = cursor_t'(selected_item - prod_id_t'(1));
    assign price     = prod_price[sel_idx];
    assign buy_ok    = buy && (selected_item != '0) && (mode != mode_returning);
    assign sell      = buy_ok && (selected_stock != '0) && (credit >= price);
    assign short_req = buy_ok && (credit < price);

    always_comb begin
        timer_done = 1'b0;
        if (mode == mode_coin_hold) begin
            timer_done = (timer == timer_w'(coin_hold_cycles - 1));
        end else if (mode == mode_returning) begin
            timer_done = (timer == timer_w'(return_step_cycles - 1));
        end
    end

    // after a sale change goes out one unit per step
    assign step_credit  = history_disabled ? (credit - money_t'(1)) : history[1];
    assign return_step  = (mode == mode_returning) && timer_done;
    // return with nothing to give back just ends
    assign return_empty = return_req && (mode != mode_returning) && (credit == '0);

    //////////////////////////////////////////////////
    // history
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < history_depth; i++) begin
                history[i] <= '0;
            end
            history_disabled <= 1'b0;
        end else if (coin_ok) begin
            history[0] <= coin_sum;
            for (int i = 1; i < history_depth; i++) begin
                history[i] <= history[i-1];
            end
        end else if (sell) begin
            history[0] <= credit - price;
            for (int i = 1; i < history_depth; i++) begin
                history[i] <= '0;
            end
            history_disabled <= 1'b1;
        end else if (return_step) begin
            if (history_disabled) begin
                history[0] <= step_credit;
            end else begin
                for (int i = 0; i < history_depth - 1; i++) begin
                    history[i] <= history[i+1];
                end
                history[history_depth-1] <= '0;
            end
            if (step_credit == '0) begin
                history_disabled <= 1'b0;
            end
        end else if (return_empty) begin
            history_disabled <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // mode FSM and timer
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            mode        <= mode_idle;
            timer       <= '0;
            sale_done   <= 1'b0;
            short_money <= 1'b0;
        end else begin
            sale_done   <= sell;
            short_money <= short_req;
            if (mode == mode_returning) begin
                if (timer_done) begin
                    timer <= '0;
                    if (step_credit == '0) begin
                        mode <= mode_idle;
                    end
                end else begin
                    timer <= timer + 1'b1;
                end
            end else if (coin_ok) begin
                // a new coin restarts the hold
                mode  <= mode_coin_hold;
                timer <= '0;
            end else if (return_req) begin
                timer <= '0;
                mode  <= (credit != '0) ? mode_returning : mode_idle;
            end else if (mode == mode_coin_hold) begin
                if (timer_done) begin
                    mode  <= mode_idle;
                    timer <= '0;
                end else begin
                    timer <= timer + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (coin_ok) begin
            coin_shown <= coin_val;
        end
    end

    assign display_money = (mode == mode_coin_hold) ? coin_shown : credit;

    a_strobes_onehot: assert property (
        @(posedge clk) disable iff (!rst)
        $onehot0({coin, buy, return_req})
    );

    // returned money only goes down
    a_return_falls: assert property (
        @(posedge clk) disable iff (!rst)
        (mode == mode_returning) |=> (display_money <= $past(display_money))
    );

endmodule

`default_nettype wire

// ==== verilog/vending_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vending_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [11:0]           buttons,
    output vending_pkg::money_t   display_money,
    output vending_pkg::count_t   prod_count_current,
    output vending_pkg::prod_id_t selected_item,
    output logic                  admin_mode,
    output logic                  sale_done,
    output logic                  short_money
);
    import vending_pkg::*;

    //////////////////////////////////////////////////
    // button bus split
    //////////////////////////////////////////////////

    wire       move_up       = buttons[btn_move_up];
    wire       move_down     = buttons[btn_move_down];
    wire       select_toggle = buttons[btn_select];
    wire       admin_toggle  = buttons[btn_admin];
    wire       buy           = buttons[btn_buy];
    wire       return_req    = buttons[btn_return];
    wire       restock       = buttons[btn_restock];
    wire [2:0] coin          = buttons[btn_coin_lo +: 3];

    // block to block
    cursor_t cursor;
    count_t  selected_stock;
    logic    sell;

    product_selector selector_i (
        .clk                (clk),
        .rst                (rst),
        .move_up            (move_up),
        .move_down          (move_down),
        .select_toggle      (select_toggle),
        .admin_toggle       (admin_toggle),
        .buy                (buy),
        .prod_count_current (prod_count_current),
        .cursor             (cursor),
        .selected_item      (selected_item),
        .admin_mode         (admin_mode)
    );

    stock_keeper stock_i (
        .clk                (clk),
        .rst                (rst),
        .cursor             (cursor),
        .selected_item      (selected_item),
        .admin_mode         (admin_mode),
        .sell               (sell),
        .restock            (restock),
        .prod_count_current (prod_count_current),
        .selected_stock     (selected_stock)
    );

    credit_ledger ledger_i (
        .clk            (clk),
        .rst            (rst),
        .coin           (coin),
        .buy            (buy),
        .return_req     (return_req),
        .selected_item  (selected_item),
        .selected_stock (selected_stock),
        .sell           (sell),
        .display_money  (display_money),
        .sale_done      (sale_done),
        .short_money    (short_money)
    );

endmodule

`default_nettype wire

// ==== dv/tb_vending_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vending_top;
    import vending_pkg::*;

    localparam int reset_cycles  = 5;
    localparam int random_cycles = 2000;
    localparam int drain_cycles  = history_depth * credit_max * return_step_cycles;
    localparam int timeout_limit = reset_cycles + random_cycles + drain_cycles + 500;

    logic        clk;
    logic        rst;
    logic [11:0] buttons;
    money_t      display_money;
    count_t      prod_count_current;
    prod_id_t    selected_item;
    logic        admin_mode;
    logic        sale_done;
    logic        short_money;

    logic [31:0] lfsr;
    int          cycle_count;

    // reference model state
    int m_cursor;
    int m_sel;
    bit m_admin;
    int m_stock [num_products];
    int m_hist [history_depth];
    bit m_hdis;
    // 0 idle, 1 coin hold, 2 returning
    int m_mode;
    int m_timer;
    int m_coin_shown;
    bit m_sale;
    bit m_short;

    vending_top dut_i (
        .clk                (clk),
        .rst                (rst),
        .buttons            (buttons),
        .display_money      (display_money),
        .prod_count_current (prod_count_current),
        .selected_item      (selected_item),
        .admin_mode         (admin_mode),
        .sale_done          (sale_done),
        .short_money        (short_money)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // random source
    //////////////////////////////////////////////////

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // coins and moves come up most often
    task automatic pick_button(output logic [11:0] b);
        int r;
        int c;
        b = '0;
        take_bits(5, r);
        if (r < 6) begin
            take_bits(2, c);
            if (c == 1) begin
                b[btn_coin_lo + 1] = 1'b1;
            end else if (c == 2) begin
                b[btn_coin_lo] = 1'b1;
            end else begin
                b[btn_coin_lo + 2] = 1'b1;
            end
        end else if (r < 10) begin
            b[btn_move_up] = 1'b1;
        end else if (r < 14) begin
            b[btn_move_down] = 1'b1;
        end else if (r < 17) begin
            b[btn_select] = 1'b1;
        end else if (r < 19) begin
            b[btn_buy] = 1'b1;
        end else if (r == 19) begin
            b[btn_return] = 1'b1;
        end else if (r == 20) begin
            b[btn_restock] = 1'b1;
        end else if (r == 21) begin
            b[btn_admin] = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    task automatic reset_model();
        m_cursor = 0;
        m_sel    = 0;
        m_admin  = 1'b0;
        for (int i = 0; i < num_products; i++) begin
            m_stock[i] = prod_init_count[i];
        end
        for (int i = 0; i < history_depth; i++) begin
            m_hist[i] = 0;
        end
        m_hdis       = 1'b0;
        m_mode       = 0;
        m_timer      = 0;
        m_coin_shown = 0;
        m_sale       = 1'b0;
        m_short      = 1'b0;
    endtask

    task automatic advance_model(input logic [11:0] b);
        int credit;
        int cval;
        int price;
        int sstock;
        int step_credit;
        int cur_stock;
        bit coin_ok;
        bit buy_ok;
        bit sell;
        bit short_req;
        bit tdone;
        credit = m_hist[0];
        cval = b[btn_coin_lo + 2] ? 1 : b[btn_coin_lo + 1] ? 5 : b[btn_coin_lo] ? 10 : 0;
        coin_ok = (cval != 0) && (credit + cval <= credit_max) && (m_mode != 2);
        sstock = (m_sel == 0) ? 0 : m_stock[m_sel - 1];
        price = (m_sel == 0) ? 0 : prod_price[m_sel - 1];
        buy_ok = b[btn_buy] && (m_sel != 0) && (m_mode != 2);
        sell = buy_ok && (sstock != 0) && (credit >= price);
        short_req = buy_ok && (credit < price);
        tdone = ((m_mode == 1) && (m_timer == coin_hold_cycles - 1)) ||
                ((m_mode == 2) && (m_timer == return_step_cycles - 1));
        step_credit = m_hdis ? credit - 1 : m_hist[1];
        cur_stock = m_stock[m_cursor];

        // stock counters
        if (sell) begin
            m_stock[m_sel - 1]--;
        end else if (b[btn_restock] && m_admin && m_stock[m_cursor] < stock_limit) begin
            m_stock[m_cursor]++;
        end

        // selection, cursor, admin
        if (b[btn_select]) begin
            if (m_sel == m_cursor + 1) begin
                m_sel = 0;
            end else if (cur_stock != 0) begin
                m_sel = m_cursor + 1;
            end
        end else if (b[btn_buy]) begin
            m_sel = 0;
        end
        if (b[btn_move_up] && m_cursor > 0) begin
            m_cursor--;
        end else if (b[btn_move_down] && m_cursor < num_products - 1) begin
            m_cursor++;
        end
        if (b[btn_admin]) begin
            m_admin = !m_admin;
        end

        // credit history
        if (coin_ok) begin
            for (int i = history_depth - 1; i > 0; i--) begin
                m_hist[i] = m_hist[i - 1];
            end
            m_hist[0] = credit + cval;
        end else if (sell) begin
            for (int i = 1; i < history_depth; i++) begin
                m_hist[i] = 0;
            end
            m_hist[0] = credit - price;
            m_hdis = 1'b1;
        end else if (m_mode == 2 && tdone) begin
            if (m_hdis) begin
                m_hist[0] = step_credit;
            end else begin
                for (int i = 0; i < history_depth - 1; i++) begin
                    m_hist[i] = m_hist[i + 1];
                end
                m_hist[history_depth - 1] = 0;
            end
            if (step_credit == 0) begin
                m_hdis = 1'b0;
            end
        end else if (b[btn_return] && m_mode != 2 && credit == 0) begin
            m_hdis = 1'b0;
        end

        // display mode and timer
        m_sale  = sell;
        m_short = short_req;
        if (m_mode == 2) begin
            if (tdone) begin
                m_timer = 0;
                if (step_credit == 0) begin
                    m_mode = 0;
                end
            end else begin
                m_timer++;
            end
        end else if (coin_ok) begin
            m_mode  = 1;
            m_timer = 0;
        end else if (b[btn_return]) begin
            m_timer = 0;
            m_mode  = (credit != 0) ? 2 : 0;
        end else if (m_mode == 1) begin
            if (tdone) begin
                m_mode  = 0;
                m_timer = 0;
            end else begin
                m_timer++;
            end
        end
        if (coin_ok) begin
            m_coin_shown = cval;
        end
    endtask

    //////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic verify_outputs();
        check_value("display_money", display_money, (m_mode == 1) ? m_coin_shown : m_hist[0]);
        check_value("prod_count_current", prod_count_current, m_stock[m_cursor]);
        check_value("selected_item", selected_item, m_sel);
        check_value("admin_mode", admin_mode, m_admin);
        check_value("sale_done", sale_done, m_sale);
        check_value("short_money", short_money, m_short);
    endtask

    // drive on the falling edge and compare one cycle later
    task automatic apply_cycle(input logic [11:0] b);
        buttons = b;
        advance_model(b);
        @(negedge clk);
        verify_outputs();
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run hung after %0d cycles without finishing", cycle_count);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial begin
        logic [11:0] b;
        rst     = 1'b0;
        buttons = '0;
        lfsr    = 32'hb94b;
        reset_model();
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b1;
        verify_outputs();

        for (int n = 0; n < random_cycles; n++) begin
            pick_button(b);
            apply_cycle(b);
        end

        // let a running return finish before filling past the cap
        while (m_mode == 2) begin
            apply_cycle('0);
        end
        repeat (10) apply_cycle(12'(1) << btn_coin_lo);
        apply_cycle(12'(1) << btn_return);
        while (m_mode == 2) begin
            apply_cycle('0);
        end
        check_value("display_money", display_money, 0);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vending_top.f ====
verilog/vending_pkg.sv
verilog/product_selector.sv
verilog/stock_keeper.sv
verilog/credit_ledger.sv
verilog/vending_top.sv
dv/tb_vending_top.sv

// ==== Bender.yml ====
package:
  name: vending_top

sources:
  - verilog/vending_pkg.sv
  - verilog/product_selector.sv
  - verilog/stock_keeper.sv
  - verilog/credit_ledger.sv
  - verilog/vending_top.sv
  - target: simulation
    files:
      - dv/tb_vending_top.sv
